// File: src/rvv_alu_pkg.sv
// micro-op definitions for the vector integer ALU
// opcode and element width encodings, vector data type and element helpers
// modules import this inside their body and use scoped names in port lists

`default_nettype none

package rvv_alu_pkg;

  // vector register length in bits
  localparam int VLEN = 128;
  // bytes per register, one adder slice or popcount per byte
  localparam int VLENB = VLEN / 8;
  // widest element the unit handles
  localparam int ELEM_W_MAX = 32;
  // enough bits to count every bit of a register
  localparam int CPOP_W = $clog2(VLEN) + 1;

  typedef logic [VLEN-1:0] vreg_t;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  typedef enum logic [4:0] {
    OP_VADD   = 5'd0,
    OP_VSUB   = 5'd1,
    OP_VRSUB  = 5'd2,
    OP_VSLL   = 5'd3,
    OP_VSRL   = 5'd4,
    OP_VSRA   = 5'd5,
    OP_VMAND  = 5'd6,
    OP_VMOR   = 5'd7,
    OP_VMXOR  = 5'd8,
    OP_VMNAND = 5'd9,
    OP_VCPOP  = 5'd10,
    OP_VMIN   = 5'd11,
    OP_VMINU  = 5'd12,
    OP_VMAX   = 5'd13,
    OP_VMAXU  = 5'd14,
    OP_VMV    = 5'd15
  } alu_op_e;

  // widen an element of the given width to ELEM_W_MAX+1 bits
  // every bit above the element takes the fill value
  function automatic logic [ELEM_W_MAX:0] elem_extend(
    input logic [ELEM_W_MAX-1:0] elem,
    input int unsigned           width,
    input logic                  fill
  );
    logic [ELEM_W_MAX-1:0] lo_mask;
    lo_mask = ELEM_W_MAX'((33'h1 << width) - 33'h1);
    return {fill, (elem & lo_mask) | ({ELEM_W_MAX{fill}} & ~lo_mask)};
  endfunction

endpackage

`default_nettype wire

// File: src/rvv_rob_pkg.sv
// reorder-buffer side definitions for the vector backend
// every unit that returns results to the ROB tags them with rob_idx_t

`default_nettype none

package rvv_rob_pkg;

  // ROB entry index width, 32 entries
  localparam int ROB_IDX_W = 5;

  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

endpackage

`default_nettype wire

// File: src/rvv_alu_addsub.sv
// add/subtract group of the vector ALU
// vadd, vsub and vrsub on one chain of 8-bit slices
// the carry between slices is cut at each element boundary

`timescale 1ns/10ps
`default_nettype none

module rvv_alu_addsub (
  input  logic                  uop_valid,
  input  rvv_alu_pkg::alu_op_e  uop_opcode,
  input  rvv_alu_pkg::sew_e     uop_sew,
  input  rvv_alu_pkg::vreg_t    uop_vs1,
  input  rvv_alu_pkg::vreg_t    uop_vs2,
  input  rvv_rob_pkg::rob_idx_t uop_rob_idx,
  output logic                  result_valid,
  output rvv_alu_pkg::vreg_t    result_data,
  output rvv_rob_pkg::rob_idx_t result_rob_idx
);

  import rvv_alu_pkg::*;

  logic             is_group;
  logic             is_sub;
  logic             is_rsub;
  vreg_t            op_a;
  vreg_t            op_b;
  logic [VLENB-1:0] lane_start;
  logic [8:0]       slice_sum [VLENB];

  always_comb begin
    is_group = 1'b1;
    is_sub   = 1'b0;
    is_rsub  = 1'b0;
    case (uop_opcode)
      OP_VADD: begin
        is_sub = 1'b0;
      end
      OP_VSUB: begin
        is_sub = 1'b1;
      end
      OP_VRSUB: begin
        is_sub  = 1'b1;
        is_rsub = 1'b1;
      end
      default: begin
        is_group = 1'b0;
      end
    endcase
  end

  // a - b is a + ~b + 1, vrsub just swaps the operands first
  assign op_a = is_rsub ? uop_vs1 : uop_vs2;
  assign op_b = (is_rsub ? uop_vs2 : uop_vs1) ^ {VLEN{is_sub}};

  // slices that begin a new element
  always_comb begin
    for (int i = 0; i < VLENB; i++) begin
      case (uop_sew)
        SEW8:    lane_start[i] = 1'b1;
        SEW16:   lane_start[i] = (i % 2) == 0;
        default: lane_start[i] = (i % 4) == 0;
      endcase
    end
  end

  for (genvar i = 0; i < VLENB; i++) begin : g_slice
    logic cin;
    if (i == 0) begin : g_first
      assign cin = is_sub;
    end else begin : g_chain
      assign cin = lane_start[i] ? is_sub : slice_sum[i-1][8];
    end
    assign slice_sum[i] = {1'b0, op_a[8*i +: 8]} + {1'b0, op_b[8*i +: 8]} + {8'd0, cin};
    assign result_data[8*i +: 8] = slice_sum[i][7:0];
  end

  assign result_valid   = uop_valid & is_group;
  assign result_rob_idx = uop_rob_idx;

endmodule

`default_nettype wire

// File: src/rvv_alu_shift.sv
// shift group of the vector ALU
// vsll, vsrl and vsra per element at the selected SEW
// amount is the low log2(SEW) bits of the matching vs1 element

`timescale 1ns/10ps
`default_nettype none

module rvv_alu_shift (
  input  logic                  uop_valid,
  input  rvv_alu_pkg::alu_op_e  uop_opcode,
  input  rvv_alu_pkg::sew_e     uop_sew,
  input  rvv_alu_pkg::vreg_t    uop_vs1,
  input  rvv_alu_pkg::vreg_t    uop_vs2,
  input  rvv_rob_pkg::rob_idx_t uop_rob_idx,
  output logic                  result_valid,
  output rvv_alu_pkg::vreg_t    result_data,
  output rvv_rob_pkg::rob_idx_t result_rob_idx
);

  import rvv_alu_pkg::*;

  logic  is_group;
  logic  is_left;
  logic  is_arith;
  vreg_t res_e8;
  vreg_t res_e16;
  vreg_t res_e32;

  // one barrel shift on an element of the given width
  function automatic logic [ELEM_W_MAX-1:0] shift_elem(
    input logic [ELEM_W_MAX-1:0] elem,
    input logic [4:0]            amt_raw,
    input logic                  left,
    input logic                  arith,
    input int unsigned           width
  );
    logic [4:0]          amt;
    logic [ELEM_W_MAX:0] wide;
    logic [ELEM_W_MAX:0] shifted;
    amt  = amt_raw & 5'(width - 1);
    // sign fill only for vsra
    wide = elem_extend(elem, width, arith & elem[width-1]);
    if (left) begin
      shifted = wide << amt;
    end else begin
      shifted = $signed(wide) >>> amt;
    end
    return shifted[ELEM_W_MAX-1:0];
  endfunction

  assign is_group = (uop_opcode == OP_VSLL) || (uop_opcode == OP_VSRL) ||
                    (uop_opcode == OP_VSRA);
  assign is_left  = (uop_opcode == OP_VSLL);
  assign is_arith = (uop_opcode == OP_VSRA);

  always_comb begin
    for (int i = 0; i < VLEN / 8; i++) begin
      res_e8[8*i +: 8] = 8'(shift_elem(ELEM_W_MAX'(uop_vs2[8*i +: 8]),
                                       uop_vs1[8*i +: 5], is_left, is_arith, 8));
    end
    for (int i = 0; i < VLEN / 16; i++) begin
      res_e16[16*i +: 16] = 16'(shift_elem(ELEM_W_MAX'(uop_vs2[16*i +: 16]),
                                           uop_vs1[16*i +: 5], is_left, is_arith, 16));
    end
    for (int i = 0; i < VLEN / 32; i++) begin
      res_e32[32*i +: 32] = shift_elem(uop_vs2[32*i +: 32],
                                       uop_vs1[32*i +: 5], is_left, is_arith, 32);
    end
  end

  always_comb begin
    case (uop_sew)
      SEW8:    result_data = res_e8;
      SEW16:   result_data = res_e16;
      default: result_data = res_e32;
    endcase
  end

  assign result_valid   = uop_valid & is_group;
  assign result_rob_idx = uop_rob_idx;

endmodule

`default_nettype wire

// File: src/rvv_alu_mask.sv
// mask group of the vector ALU
// vmand, vmor, vmxor and vmnand act on the whole register in the issue cycle
// vcpop registers per-byte counts on issue and holds the summed count
// until the ROB takes it, with cpop_busy raised over that span

`timescale 1ns/10ps
`default_nettype none

module rvv_alu_mask (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  uop_valid,
  input  rvv_alu_pkg::alu_op_e  uop_opcode,
  input  rvv_alu_pkg::vreg_t    uop_vs1,
  input  rvv_alu_pkg::vreg_t    uop_vs2,
  input  rvv_rob_pkg::rob_idx_t uop_rob_idx,
  input  logic                  result_ready,
  output logic                  result_valid,
  output rvv_alu_pkg::vreg_t    result_data,
  output rvv_rob_pkg::rob_idx_t result_rob_idx,
  output logic                  cpop_busy
);

  import rvv_alu_pkg::*;
  import rvv_rob_pkg::*;

  typedef enum logic {
    CPOP_IDLE,
    CPOP_HOLD
  } cpop_state_e;

  cpop_state_e       state_q;
  cpop_state_e       state_d;
  logic              is_logic;
  logic              cpop_fire;
  vreg_t             logic_data;
  logic [3:0]        byte_cnt_q [VLENB];
  rob_idx_t          cpop_rob_idx_q;
  logic [CPOP_W-1:0] cpop_sum;

  function automatic logic [3:0] byte_ones(input logic [7:0] b);
    logic [3:0] n;
    n = '0;
    for (int k = 0; k < 8; k++) begin
      n = n + {3'd0, b[k]};
    end
    return n;
  endfunction

  always_comb begin
    is_logic   = 1'b1;
    logic_data = '0;
    case (uop_opcode)
      OP_VMAND:  logic_data = uop_vs2 & uop_vs1;
      OP_VMOR:   logic_data = uop_vs2 | uop_vs1;
      OP_VMXOR:  logic_data = uop_vs2 ^ uop_vs1;
      OP_VMNAND: logic_data = ~(uop_vs2 & uop_vs1);
      default:   is_logic   = 1'b0;
    endcase
  end

  // vcpop is taken only when the ROB side is ready in the issue cycle
  assign cpop_fire = uop_valid & result_ready & (uop_opcode == OP_VCPOP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      CPOP_IDLE: begin
        if (cpop_fire) begin
          state_d = CPOP_HOLD;
        end
      end
      CPOP_HOLD: begin
        if (result_ready) begin
          state_d = CPOP_IDLE;
        end
      end
      default: state_d = CPOP_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= CPOP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // first stage, one count per byte
  always_ff @(posedge clk) begin
    if (cpop_fire) begin
      for (int i = 0; i < VLENB; i++) begin
        byte_cnt_q[i] <= byte_ones(uop_vs2[8*i +: 8]);
      end
      cpop_rob_idx_q <= uop_rob_idx;
    end
  end

  // second stage, add up the byte counts
  always_comb begin
    cpop_sum = '0;
    for (int i = 0; i < VLENB; i++) begin
      cpop_sum = cpop_sum + CPOP_W'(byte_cnt_q[i]);
    end
  end

  assign cpop_busy      = (state_q == CPOP_HOLD);
  assign result_valid   = (uop_valid & is_logic) | cpop_busy;
  assign result_data    = cpop_busy ? VLEN'(cpop_sum) : logic_data;
  assign result_rob_idx = cpop_busy ? cpop_rob_idx_q : uop_rob_idx;

endmodule

`default_nettype wire

// File: src/rvv_alu_other.sv
// min/max and move group of the vector ALU
// vmin, vminu, vmax and vmaxu per element at the selected SEW, vmv copies vs1

`timescale 1ns/10ps
`default_nettype none

module rvv_alu_other (
  input  logic                  uop_valid,
  input  rvv_alu_pkg::alu_op_e  uop_opcode,
  input  rvv_alu_pkg::sew_e     uop_sew,
  input  rvv_alu_pkg::vreg_t    uop_vs1,
  input  rvv_alu_pkg::vreg_t    uop_vs2,
  input  rvv_rob_pkg::rob_idx_t uop_rob_idx,
  output logic                  result_valid,
  output rvv_alu_pkg::vreg_t    result_data,
  output rvv_rob_pkg::rob_idx_t result_rob_idx
);

  import rvv_alu_pkg::*;

  logic  is_group;
  logic  is_mv;
  logic  is_signed;
  logic  take_max;
  vreg_t res_e8;
  vreg_t res_e16;
  vreg_t res_e32;

  // compare a (vs2 lane) with b (vs1 lane) and keep the min or the max
  function automatic logic [ELEM_W_MAX-1:0] pick_elem(
    input logic [ELEM_W_MAX-1:0] a,
    input logic [ELEM_W_MAX-1:0] b,
    input logic                  sgn,
    input logic                  max,
    input int unsigned           width
  );
    logic [ELEM_W_MAX:0] a_ext;
    logic [ELEM_W_MAX:0] b_ext;
    logic                a_lt_b;
    a_ext  = elem_extend(a, width, sgn & a[width-1]);
    b_ext  = elem_extend(b, width, sgn & b[width-1]);
    a_lt_b = $signed(a_ext) < $signed(b_ext);
    return (a_lt_b ^ max) ? a : b;
  endfunction

  assign is_mv     = (uop_opcode == OP_VMV);
  assign is_signed = (uop_opcode == OP_VMIN) || (uop_opcode == OP_VMAX);
  assign take_max  = (uop_opcode == OP_VMAX) || (uop_opcode == OP_VMAXU);
  assign is_group  = is_mv || is_signed || take_max || (uop_opcode == OP_VMINU);

  always_comb begin
    for (int i = 0; i < VLEN / 8; i++) begin
      res_e8[8*i +: 8] = 8'(pick_elem(ELEM_W_MAX'(uop_vs2[8*i +: 8]),
                                      ELEM_W_MAX'(uop_vs1[8*i +: 8]), is_signed, take_max, 8));
    end
    for (int i = 0; i < VLEN / 16; i++) begin
      res_e16[16*i +: 16] = 16'(pick_elem(ELEM_W_MAX'(uop_vs2[16*i +: 16]),
                                          ELEM_W_MAX'(uop_vs1[16*i +: 16]),
                                          is_signed, take_max, 16));
    end
    for (int i = 0; i < VLEN / 32; i++) begin
      res_e32[32*i +: 32] = pick_elem(uop_vs2[32*i +: 32], uop_vs1[32*i +: 32],
                                      is_signed, take_max, 32);
    end
  end

  always_comb begin
    if (is_mv) begin
      result_data = uop_vs1;
    end else begin
      case (uop_sew)
        SEW8:    result_data = res_e8;
        SEW16:   result_data = res_e16;
        default: result_data = res_e32;
      endcase
    end
  end

  assign result_valid   = uop_valid & is_group;
  assign result_rob_idx = uop_rob_idx;

endmodule

`default_nettype wire

// File: src/rvv_alu_unit.sv
// integer ALU unit of the vector backend
// takes micro-ops from the issue stage, runs them in one of four groups
// and hands the single valid result to the ROB over valid/ready

`timescale 1ns/10ps
`default_nettype none

module rvv_alu_unit (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  uop_valid,
  input  rvv_alu_pkg::alu_op_e  uop_opcode,
  input  rvv_alu_pkg::sew_e     uop_sew,
  input  rvv_alu_pkg::vreg_t    uop_vs1,
  input  rvv_alu_pkg::vreg_t    uop_vs2,
  input  rvv_rob_pkg::rob_idx_t uop_rob_idx,
  output logic                  uop_ready,
  output logic                  result_valid,
  output rvv_alu_pkg::vreg_t    result_data,
  output rvv_rob_pkg::rob_idx_t result_rob_idx,
  input  logic                  result_ready
);

  import rvv_alu_pkg::*;
  import rvv_rob_pkg::*;

  logic     cpop_busy;
  logic     issue_valid;
  logic     valid_addsub;
  logic     valid_shift;
  logic     valid_mask;
  logic     valid_other;
  vreg_t    data_addsub;
  vreg_t    data_shift;
  vreg_t    data_mask;
  vreg_t    data_other;
  rob_idx_t rob_addsub;
  rob_idx_t rob_shift;
  rob_idx_t rob_mask;
  rob_idx_t rob_other;

  assign uop_ready = result_ready & ~cpop_busy;

  // groups see the micro-op whenever no count is held, so a combinational
  // result stays valid under back-pressure; the mask group itself only
  // captures a vcpop when result_ready completes the issue handshake
  assign issue_valid = uop_valid & ~cpop_busy;

  rvv_alu_addsub u_addsub (
    .uop_valid      (issue_valid),
    .uop_opcode     (uop_opcode),
    .uop_sew        (uop_sew),
    .uop_vs1        (uop_vs1),
    .uop_vs2        (uop_vs2),
    .uop_rob_idx    (uop_rob_idx),
    .result_valid   (valid_addsub),
    .result_data    (data_addsub),
    .result_rob_idx (rob_addsub)
  );

  rvv_alu_shift u_shift (
    .uop_valid      (issue_valid),
    .uop_opcode     (uop_opcode),
    .uop_sew        (uop_sew),
    .uop_vs1        (uop_vs1),
    .uop_vs2        (uop_vs2),
    .uop_rob_idx    (uop_rob_idx),
    .result_valid   (valid_shift),
    .result_data    (data_shift),
    .result_rob_idx (rob_shift)
  );

  rvv_alu_mask u_mask (
    .clk            (clk),
    .arst_n         (arst_n),
    .uop_valid      (issue_valid),
    .uop_opcode     (uop_opcode),
    .uop_vs1        (uop_vs1),
    .uop_vs2        (uop_vs2),
    .uop_rob_idx    (uop_rob_idx),
    .result_ready   (result_ready),
    .result_valid   (valid_mask),
    .result_data    (data_mask),
    .result_rob_idx (rob_mask),
    .cpop_busy      (cpop_busy)
  );

  rvv_alu_other u_other (
    .uop_valid      (issue_valid),
    .uop_opcode     (uop_opcode),
    .uop_sew        (uop_sew),
    .uop_vs1        (uop_vs1),
    .uop_vs2        (uop_vs2),
    .uop_rob_idx    (uop_rob_idx),
    .result_valid   (valid_other),
    .result_data    (data_other),
    .result_rob_idx (rob_other)
  );

  // one-hot pick of the group result
  always_comb begin
    result_valid   = 1'b0;
    result_data    = '0;
    result_rob_idx = '0;
    case (1'b1)
      valid_addsub: begin
        result_valid   = 1'b1;
        result_data    = data_addsub;
        result_rob_idx = rob_addsub;
      end
      valid_shift: begin
        result_valid   = 1'b1;
        result_data    = data_shift;
        result_rob_idx = rob_shift;
      end
      valid_mask: begin
        result_valid   = 1'b1;
        result_data    = data_mask;
        result_rob_idx = rob_mask;
      end
      valid_other: begin
        result_valid   = 1'b1;
        result_data    = data_other;
        result_rob_idx = rob_other;
      end
      default: begin
        result_valid = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
// clock and reset source for the ALU unit testbench
// 4 ns clock, arst_n held low for the first 3 cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    // release mid-cycle, clear of the rising edge
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_rvv_alu_unit.sv
// directed testbench for the vector integer ALU unit
// drives micro-ops 1 ns after each rising edge, checks results mid-cycle
// against lane-by-lane models, and prints a summary at the end

`timescale 1ns/10ps
`default_nettype none

module tb_rvv_alu_unit;

  import rvv_alu_pkg::*;
  import rvv_rob_pkg::*;

  localparam int WAIT_LIMIT = 50;

  logic        clk;
  logic        arst_n;
  logic        uop_valid;
  alu_op_e     uop_opcode;
  sew_e        uop_sew;
  vreg_t       uop_vs1;
  vreg_t       uop_vs2;
  rob_idx_t    uop_rob_idx;
  logic        uop_ready;
  logic        result_valid;
  vreg_t       result_data;
  rob_idx_t    result_rob_idx;
  logic        result_ready;
  logic [31:0] lcg_state;
  int          err_count;
  int          check_count;
  int          test_count;
  int          test_err_start;

  tb_clock_gen u_clk (
    .clk    (clk),
    .arst_n (arst_n)
  );

  rvv_alu_unit dut (
    .clk            (clk),
    .arst_n         (arst_n),
    .uop_valid      (uop_valid),
    .uop_opcode     (uop_opcode),
    .uop_sew        (uop_sew),
    .uop_vs1        (uop_vs1),
    .uop_vs2        (uop_vs2),
    .uop_rob_idx    (uop_rob_idx),
    .uop_ready      (uop_ready),
    .result_valid   (result_valid),
    .result_data    (result_data),
    .result_rob_idx (result_rob_idx),
    .result_ready   (result_ready)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic vreg_t rand_vreg();
    vreg_t v;
    for (int i = 0; i < VLEN / 32; i++) begin
      v[32*i +: 32] = lcg_next();
    end
    return v;
  endfunction

  function automatic int unsigned sew_width(sew_e sew);
    case (sew)
      SEW8:    return 8;
      SEW16:   return 16;
      default: return 32;
    endcase
  endfunction

  function automatic logic [31:0] lane_mask(int unsigned w);
    return (w == 32) ? 32'hffff_ffff : ((32'h1 << w) - 32'h1);
  endfunction

  function automatic logic [31:0] lane_get(vreg_t v, int unsigned w, int unsigned i);
    logic [31:0] raw;
    raw = 32'(v >> (w * i));
    return raw & lane_mask(w);
  endfunction

  // sign of bit w-1 copied up to bit 31
  function automatic logic signed [31:0] sext(logic [31:0] x, int unsigned w);
    logic [31:0] up;
    up = x << (32 - w);
    return $signed(up) >>> (32 - w);
  endfunction

  // expected result, lane by lane with a = vs2 element and b = vs1 element
  function automatic vreg_t expected_result(alu_op_e op, sew_e sew, vreg_t vs1, vreg_t vs2);
    int unsigned w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] amt;
    logic [31:0] r;
    vreg_t       res;
    w   = sew_width(sew);
    res = '0;
    case (op)
      OP_VMAND:  return vs2 & vs1;
      OP_VMOR:   return vs2 | vs1;
      OP_VMXOR:  return vs2 ^ vs1;
      OP_VMNAND: return ~(vs2 & vs1);
      OP_VMV:    return vs1;
      OP_VCPOP: begin
        r = '0;
        for (int k = 0; k < VLEN; k++) begin
          r = r + 32'(vs2[k]);
        end
        return vreg_t'(r);
      end
      default: ;
    endcase
    for (int i = 0; i < VLEN / w; i++) begin
      a   = lane_get(vs2, w, i);
      b   = lane_get(vs1, w, i);
      amt = b & (w - 1);
      case (op)
        OP_VADD:  r = a + b;
        OP_VSUB:  r = a - b;
        OP_VRSUB: r = b - a;
        OP_VSLL:  r = a << amt;
        OP_VSRL:  r = a >> amt;
        OP_VSRA:  r = sext(a, w) >>> amt;
        OP_VMIN:  r = (sext(a, w) < sext(b, w)) ? a : b;
        OP_VMINU: r = (a < b) ? a : b;
        OP_VMAX:  r = (sext(a, w) > sext(b, w)) ? a : b;
        OP_VMAXU: r = (a > b) ? a : b;
        default:  r = '0;
      endcase
      res = res | (vreg_t'(r & lane_mask(w)) << (w * i));
    end
    return res;
  endfunction

  task automatic check_data(string name, vreg_t got, vreg_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_rob_idx(string name, rob_idx_t got, rob_idx_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic abort_run(string what);
    $display("Timeout while waiting for %s, giving up", what);
    $display(">>> FAIL");
    $finish;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic begin_test();
    test_err_start = err_count;
  endtask

  task automatic end_test(string name);
    test_count++;
    $display("test %-14s done, %0d errors", name, err_count - test_err_start);
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (arst_n !== 1'b1 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (arst_n !== 1'b1) begin
      abort_run("reset release");
    end
  endtask

  task automatic wait_uop_ready();
    int n;
    n = 0;
    while (uop_ready !== 1'b1 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (uop_ready !== 1'b1) begin
      abort_run("uop_ready");
    end
  endtask

  task automatic wait_result_valid(output int cycles);
    cycles = 0;
    while (result_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
      next_cycle();
      cycles++;
    end
    if (result_valid !== 1'b1) begin
      abort_run("result_valid");
    end
  endtask

  task automatic drive_uop(alu_op_e op, sew_e sew, vreg_t vs1, vreg_t vs2, rob_idx_t rob);
    uop_valid   = 1'b1;
    uop_opcode  = op;
    uop_sew     = sew;
    uop_vs1     = vs1;
    uop_vs2     = vs2;
    uop_rob_idx = rob;
  endtask

  // one zero-latency micro-op, checked in its issue cycle
  task automatic run_comb(alu_op_e op, sew_e sew, vreg_t vs1, vreg_t vs2);
    rob_idx_t rob;
    vreg_t    exp;
    rob = rob_idx_t'(lcg_next() >> 11);
    exp = expected_result(op, sew, vs1, vs2);
    wait_uop_ready();
    drive_uop(op, sew, vs1, vs2, rob);
    #1;
    check_bit("uop_ready", uop_ready, 1'b1);
    check_bit("result_valid", result_valid, 1'b1);
    check_data({"result_data ", op.name(), " ", sew.name()}, result_data, exp);
    check_rob_idx("result_rob_idx", result_rob_idx, rob);
    next_cycle();
    uop_valid = 1'b0;
  endtask

  task automatic sweep_sew(alu_op_e op, vreg_t dir_vs1, vreg_t dir_vs2);
    sew_e sew;
    for (int s = 0; s < 3; s++) begin
      sew = sew_e'(s);
      run_comb(op, sew, rand_vreg(), rand_vreg());
      run_comb(op, sew, rand_vreg(), rand_vreg());
      run_comb(op, sew, dir_vs1, dir_vs2);
    end
  endtask

  task automatic test_reset_state();
    begin_test();
    result_ready = 1'b0;
    #1;
    check_bit("result_valid", result_valid, 1'b0);
    check_bit("uop_ready", uop_ready, 1'b0);
    // no group valid, so the result fields read zero
    check_data("result_data idle", result_data, '0);
    check_rob_idx("result_rob_idx idle", result_rob_idx, '0);
    next_cycle();
    result_ready = 1'b1;
    #1;
    check_bit("result_valid", result_valid, 1'b0);
    check_bit("uop_ready", uop_ready, 1'b1);
    next_cycle();
    end_test("reset_state");
  endtask

  task automatic test_addsub();
    begin_test();
    // all-ones plus one wraps every lane
    sweep_sew(OP_VADD, {16{8'h01}}, {16{8'hff}});
    sweep_sew(OP_VSUB, {16{8'h01}}, {16{8'h00}});
    sweep_sew(OP_VRSUB, {16{8'h00}}, {16{8'h01}});
    end_test("addsub");
  endtask

  task automatic test_shift();
    begin_test();
    // negative lanes, raw amounts above log2(SEW)
    sweep_sew(OP_VSLL, {16{8'hef}}, {16{8'h96}});
    sweep_sew(OP_VSRL, {16{8'hef}}, {16{8'h96}});
    sweep_sew(OP_VSRA, {16{8'hef}}, {16{8'h96}});
    sweep_sew(OP_VSRA, {16{8'h3a}}, {16{8'hc1}});
    end_test("shift");
  endtask

  task automatic test_other();
    begin_test();
    // 0x7f.. vs 0x81.. orders differently signed and unsigned
    sweep_sew(OP_VMIN, {16{8'h81}}, {16{8'h7f}});
    sweep_sew(OP_VMINU, {16{8'h81}}, {16{8'h7f}});
    sweep_sew(OP_VMAX, {16{8'h81}}, {16{8'h7f}});
    sweep_sew(OP_VMAXU, {16{8'h81}}, {16{8'h7f}});
    sweep_sew(OP_VMV, rand_vreg(), rand_vreg());
    end_test("other");
  endtask

  task automatic test_mask();
    vreg_t    vs2;
    vreg_t    exp;
    vreg_t    add_vs1;
    vreg_t    add_vs2;
    rob_idx_t rob;
    rob_idx_t add_rob;
    int       late;
    begin_test();
    sweep_sew(OP_VMAND, rand_vreg(), rand_vreg());
    sweep_sew(OP_VMOR, rand_vreg(), rand_vreg());
    sweep_sew(OP_VMXOR, rand_vreg(), rand_vreg());
    sweep_sew(OP_VMNAND, rand_vreg(), rand_vreg());

    vs2     = rand_vreg();
    rob     = rob_idx_t'(lcg_next() >> 11);
    exp     = expected_result(OP_VCPOP, SEW8, '0, vs2);
    add_vs1 = rand_vreg();
    add_vs2 = rand_vreg();
    add_rob = rob_idx_t'(lcg_next() >> 11);
    wait_uop_ready();
    drive_uop(OP_VCPOP, SEW8, '0, vs2, rob);
    #1;
    check_bit("uop_ready vcpop issue", uop_ready, 1'b1);
    check_bit("result_valid vcpop issue", result_valid, 1'b0);
    next_cycle();
    uop_valid    = 1'b0;
    result_ready = 1'b0;
    wait_result_valid(late);
    if (late != 0) begin
      err_count++;
      $display("vcpop result arrived %0d cycles later than one cycle after issue", late);
    end
    // a vadd waits behind the held count
    drive_uop(OP_VADD, SEW32, add_vs1, add_vs2, add_rob);
    repeat (4) begin
      #1;
      check_bit("uop_ready vcpop hold", uop_ready, 1'b0);
      check_bit("result_valid vcpop hold", result_valid, 1'b1);
      check_data("result_data vcpop", result_data, exp);
      check_rob_idx("result_rob_idx vcpop", result_rob_idx, rob);
      next_cycle();
    end
    result_ready = 1'b1;
    #1;
    check_bit("uop_ready vcpop transfer", uop_ready, 1'b0);
    check_bit("result_valid vcpop transfer", result_valid, 1'b1);
    check_data("result_data vcpop", result_data, exp);
    next_cycle();
    #1;
    check_bit("uop_ready after vcpop", uop_ready, 1'b1);
    check_bit("result_valid after vcpop", result_valid, 1'b1);
    check_data("result_data OP_VADD", result_data,
               expected_result(OP_VADD, SEW32, add_vs1, add_vs2));
    check_rob_idx("result_rob_idx OP_VADD", result_rob_idx, add_rob);
    next_cycle();
    uop_valid = 1'b0;
    end_test("mask");
  endtask

  task automatic test_backpressure();
    vreg_t    vs1;
    vreg_t    vs2;
    vreg_t    exp;
    rob_idx_t rob;
    begin_test();
    vs1 = rand_vreg();
    vs2 = rand_vreg();
    rob = rob_idx_t'(lcg_next() >> 11);
    exp = expected_result(OP_VSUB, SEW16, vs1, vs2);
    result_ready = 1'b0;
    drive_uop(OP_VSUB, SEW16, vs1, vs2, rob);
    repeat (3) begin
      #1;
      check_bit("uop_ready stalled", uop_ready, 1'b0);
      check_bit("result_valid stalled", result_valid, 1'b1);
      check_data("result_data OP_VSUB", result_data, exp);
      check_rob_idx("result_rob_idx", result_rob_idx, rob);
      next_cycle();
    end
    result_ready = 1'b1;
    #1;
    check_bit("uop_ready released", uop_ready, 1'b1);
    check_bit("result_valid released", result_valid, 1'b1);
    check_data("result_data OP_VSUB", result_data, exp);
    next_cycle();
    uop_valid = 1'b0;
    #1;
    check_bit("result_valid after accept", result_valid, 1'b0);
    next_cycle();
    end_test("backpressure");
  endtask

  initial begin
    lcg_state    = 32'hf0dc_c0bd;
    err_count    = 0;
    check_count  = 0;
    test_count   = 0;
    uop_valid    = 1'b0;
    uop_opcode   = OP_VADD;
    uop_sew      = SEW8;
    uop_vs1      = '0;
    uop_vs2      = '0;
    uop_rob_idx  = '0;
    result_ready = 1'b0;

    wait_reset_release();
    test_reset_state();
    test_addsub();
    test_shift();
    test_other();
    test_mask();
    test_backpressure();

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
src/rvv_alu_pkg.sv
src/rvv_rob_pkg.sv
src/rvv_alu_addsub.sv
src/rvv_alu_shift.sv
src/rvv_alu_mask.sv
src/rvv_alu_other.sv
src/rvv_alu_unit.sv
test/tb_clock_gen.sv
test/tb_rvv_alu_unit.sv

// File: Bender.yml
package:
  name: rvv_alu_unit

sources:
  - src/rvv_alu_pkg.sv
  - src/rvv_rob_pkg.sv
  - src/rvv_alu_addsub.sv
  - src/rvv_alu_shift.sv
  - src/rvv_alu_mask.sv
  - src/rvv_alu_other.sv
  - src/rvv_alu_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_rvv_alu_unit.sv
